/* ramio.f */
source/ramio_pkg.sv
source/ramio_uart_tx.sv
source/ramio_uart_rx.sv
source/ramio_cache.sv
source/ramio.sv
sim/burst_ram_model.sv
sim/ramio_checker.sv
sim/ramio_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the ramio testbench with verilator and runs it
# the exit status of the simulation decides pass or fail

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -j 0 --top-module ramio_tb \
    -Mdir obj_dir -f ramio.f &&
  ./obj_dir/Vramio_tb ||
  exit 1

/* sim/ramio_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio_tb
  import ramio_pkg::*;
();

  localparam int ram_bits       = 12;
  localparam int line_ix_bits   = 2;
  localparam int clk_freq       = 1_000_000;
  localparam int baud_rate      = 125_000;
  localparam int bit_cycles     = clk_freq / baud_rate;
  localparam int ram_bytes      = 1 << ram_bits;
  localparam int alias_stride   = line_bytes << line_ix_bits;  // same line index
  localparam int timeout_cycles = 200_000;  // ~1500 accesses x 60 cycles plus uart

  logic        clk = 1'b0;
  logic        reset;
  logic        enable;
  write_type_t write_type;
  read_type_t  read_type;
  word_t       address;
  word_t       data_in;
  word_t       data_out;
  logic        data_out_ready;
  logic        busy;
  logic [3:0]  led;
  logic        uart_tx;
  logic        uart_rx;
  logic        br_cmd;
  logic        br_cmd_en;
  br_addr_t    br_addr;
  beat_t       br_wr_data;
  logic [7:0]  br_data_mask;
  beat_t       br_rd_data;
  logic        br_rd_data_valid;

  // reference model
  byte_t      ref_mem [ram_bytes];
  logic [3:0] exp_led;
  byte_t      tx_expect [$];
  int         tx_count = 0;  // bytes decoded so far
  int         cycles = 0;

  always #10 clk = ~clk;

  ramio #(
    .RAM_DEPTH_BITWIDTH    (ram_bits),
    .CACHE_LINE_IX_BITWIDTH(line_ix_bits),
    .CLK_FREQ              (clk_freq),
    .BAUD_RATE             (baud_rate)
  ) ramio_i (
    .clk(clk), .reset(reset), .enable(enable), .write_type(write_type),
    .read_type(read_type), .address(address), .data_in(data_in), .data_out(data_out),
    .data_out_ready(data_out_ready), .busy(busy), .led(led), .uart_tx(uart_tx),
    .uart_rx(uart_rx), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_data_mask(br_data_mask), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  burst_ram_model #(.ADDR_BITS(ram_bits)) ram_model_i (
    .clk(clk), .reset(reset), .br_cmd(br_cmd), .br_cmd_en(br_cmd_en), .br_addr(br_addr),
    .br_wr_data(br_wr_data), .br_data_mask(br_data_mask), .br_rd_data(br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  // ----------------------------------------
  // failure reporting and compares
  // ----------------------------------------
  task automatic abort_run();
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failed check");
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_led(input string name, input logic [3:0] got, input logic [3:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(input string name, input byte_t got, input byte_t exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_two_cycles(input string what, input int lat);
    if (lat != 2) begin
      $display("%s answered after %0d cycles instead of two", what, lat);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= timeout_cycles) begin
      $display("the run did not finish within %0d clock cycles", timeout_cycles);
      abort_run();
    end
  end

  // ----------------------------------------
  // reference model rules
  // ----------------------------------------
  function automatic int write_bytes(input write_type_t wt);
    return (wt == wt_word) ? 4 : (wt == wt_half) ? 2 : 1;
  endfunction

  function automatic int read_bytes(input read_type_t rt);
    return (rt == rt_word) ? 4 : (rt == rt_half || rt == rt_half_u) ? 2 : 1;
  endfunction

  function automatic void store_ref(input write_type_t wt, input int a, input word_t d);
    for (int i = 0; i < write_bytes(wt); i++) ref_mem[a + i] = d[8*i +: 8];  // little endian
  endfunction

  function automatic word_t expected_read(input read_type_t rt, input int a);
    case (rt)
      rt_byte:   return {{24{ref_mem[a][7]}}, ref_mem[a]};
      rt_byte_u: return {24'h0, ref_mem[a]};
      rt_half:   return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
      rt_half_u: return {16'h0, ref_mem[a+1], ref_mem[a]};
      default:   return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
    endcase
  endfunction

  // ----------------------------------------
  // core side accesses, entered on a falling edge
  // ----------------------------------------
  task automatic run_access(input write_type_t wt, input read_type_t rt, input word_t addr,
                            input word_t wdata, output word_t rdata, output int lat);
    int start;
    start      = cycles;
    rdata      = '0;
    lat        = 0;
    enable     = 1'b1;
    write_type = wt;
    read_type  = rt;
    address    = addr;
    data_in    = wdata;
    @(negedge clk);
    enable     = 1'b0;
    write_type = wt_none;
    read_type  = rt_none;
    if (rt != rt_none) begin
      while (!data_out_ready) @(negedge clk);
      rdata = data_out;
      lat   = cycles - start;  // edges from enable to the ready edge
    end
    while (busy) @(negedge clk);
    if (rt == rt_none) lat = cycles - start - 1;
    check_led("led", led, exp_led);  // led must hold across every access
  endtask

  task automatic write_ram(input write_type_t wt, input int a, input word_t d, output int lat);
    word_t unused;
    run_access(wt, rt_none, word_t'(a), d, unused, lat);
    store_ref(wt, a, d);
  endtask

  task automatic read_ram(input read_type_t rt, input int a, output int lat);
    word_t got;
    run_access(wt_none, rt, word_t'(a), '0, got, lat);
    check_word("data_out", got, expected_read(rt, a));
  endtask

  task automatic read_uart_in(input word_t exp);
    word_t got;
    int    lat;
    run_access(wt_none, rt_byte_u, io_uart_in_addr, '0, got, lat);
    check_word("data_out", got, exp);
    check_two_cycles("uart receive read", lat);
  endtask

  // 8N1 frame on uart_rx, lsb first
  task automatic send_rx_byte(input byte_t b);
    uart_rx = 1'b0;
    repeat (bit_cycles) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      uart_rx = b[i];
      repeat (bit_cycles) @(negedge clk);
    end
    uart_rx = 1'b1;
    repeat (bit_cycles) @(negedge clk);
  endtask

  // ----------------------------------------
  // uart_tx decoder, samples at mid-bit
  // ----------------------------------------
  initial begin
    byte_t got;
    forever begin
      @(negedge clk);
      if (reset === 1'b0 && uart_tx === 1'b0) begin
        repeat (bit_cycles / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
          $display("uart_tx start bit ended before mid-bit at %0t", $time);
          abort_run();
        end
        for (int i = 0; i < 8; i++) begin
          repeat (bit_cycles) @(negedge clk);
          got[i] = uart_tx;
        end
        repeat (bit_cycles) @(negedge clk);
        if (uart_tx !== 1'b1) begin
          $display("uart_tx stop bit missing at %0t", $time);
          abort_run();
        end
        if (tx_count >= tx_expect.size()) begin
          $display("uart_tx sent a byte that was never written");
          abort_run();
        end
        check_byte("uart_tx", got, tx_expect[tx_count]);
        tx_count = tx_count + 1;
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  initial begin
    word_t       got;
    word_t       d;
    int          lat;
    int          a;
    int          base;
    byte_t       b;
    write_type_t wt;
    read_type_t  rt;
    void'($urandom(69683));
    reset      = 1'b1;
    enable     = 1'b0;
    write_type = wt_none;
    read_type  = rt_none;
    address    = '0;
    data_in    = '0;
    uart_rx    = 1'b1;
    exp_led    = '0;
    for (int i = 0; i < ram_bytes; i++) ref_mem[i] = '0;
    repeat (3) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);
    check_led("led", led, 4'h0);
    read_uart_in('1);  // nothing received yet

    // random traffic over the whole ram
    for (int n = 0; n < 600; n++) begin
      if ($urandom % 2 == 0) begin
        wt = write_type_t'(1 + $urandom % 3);
        a  = int'($urandom % ram_bytes) & ~(write_bytes(wt) - 1);
        write_ram(wt, a, $urandom, lat);
      end else begin
        rt = read_type_t'(1 + $urandom % 5);
        a  = int'($urandom % ram_bytes) & ~(read_bytes(rt) - 1);
        read_ram(rt, a, lat);
      end
    end

    // aliasing lines, dirty evictions
    for (int r = 0; r < 20; r++) begin
      base = int'($urandom % alias_stride) & ~3;
      for (int k = 0; k < 8; k++) write_ram(wt_word, base + k * alias_stride, $urandom, lat);
      for (int k = 0; k < 8; k++) read_ram(rt_word, base + k * alias_stride, lat);
    end

    // led register
    for (int n = 0; n < 10; n++) begin
      d       = $urandom;
      exp_led = d[3:0];
      run_access(wt_byte, rt_none, io_led_addr, d, got, lat);
      check_two_cycles("led write", lat);
      for (int k = 0; k < 3; k++) read_ram(rt_word, int'($urandom % ram_bytes) & ~3, lat);
    end

    // uart transmit, three back to back per group
    for (int g = 0; g < 4; g++) begin
      for (int k = 0; k < 3; k++) begin
        b = byte_t'($urandom);
        tx_expect.push_back(b);
        run_access(wt_byte, rt_none, io_uart_out_addr, word_t'(b), got, lat);
      end
      read_ram(rt_half_u, int'($urandom % ram_bytes) & ~1, lat);
    end
    while (tx_count < tx_expect.size()) @(negedge clk);

    // uart receive
    for (int n = 0; n < 6; n++) begin
      b = byte_t'($urandom);
      send_rx_byte(b);
      repeat (2) @(negedge clk);
      read_uart_in({24'h0, b});
      read_uart_in('1);  // holding register cleared
    end
    send_rx_byte(8'h5a);
    send_rx_byte(8'ha5);  // overwrites the held byte
    repeat (2) @(negedge clk);
    read_uart_in(32'h0000_00a5);

    // hits right after a completed access
    for (int n = 0; n < 40; n++) begin
      a = int'($urandom % ram_bytes) & ~3;
      write_ram(wt_word, a, $urandom, lat);
      read_ram(rt_word, a, lat);
      check_two_cycles("cache read hit", lat);
      write_ram(wt_byte, a + 1, $urandom, lat);
      check_two_cycles("cache write hit", lat);
      read_ram(rt_byte, a + 1, lat);
      check_two_cycles("cache read hit", lat);
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/ramio_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio_checker
  import ramio_pkg::*;
(
  input wire              clk,
  input wire              reset,
  input wire              enable,
  input wire write_type_t write_type,
  input wire read_type_t  read_type,
  input wire word_t       address,
  input wire              busy,
  input wire              data_out_ready
);

  logic to_io;
  logic half_access;
  logic word_access;
  logic misaligned;

  assign to_io = (address == io_led_addr) || (address == io_uart_out_addr) ||
                 (address == io_uart_in_addr);
  assign half_access = (write_type == wt_half) || (read_type == rt_half) ||
                       (read_type == rt_half_u);
  assign word_access = (write_type == wt_word) || (read_type == rt_word);
  // aligned accesses never cross a 32 byte line
  assign misaligned  = !to_io && ((half_access && address[0]) ||
                                  (word_access && address[1:0] != 2'b00));

  // ----------------------------------------
  // core side protocol
  // ----------------------------------------
  enable_not_busy: assert property (@(posedge clk) disable iff (reset) enable |-> !busy)
    else $error("enable pulsed while busy was high");

  one_type: assert property (@(posedge clk) disable iff (reset)
    enable |-> ((write_type != wt_none) != (read_type != rt_none)))
    else $error("enable without exactly one access type");

  ram_aligned: assert property (@(posedge clk) disable iff (reset) enable |-> !misaligned)
    else $error("misaligned ram access at %h", address);

  ready_in_busy: assert property (@(posedge clk) disable iff (reset) data_out_ready |-> busy)
    else $error("data_out_ready outside of busy");

endmodule

bind ramio ramio_checker checker_i (
  .clk           (clk),
  .reset         (reset),
  .enable        (enable),
  .write_type    (write_type),
  .read_type     (read_type),
  .address       (address),
  .busy          (busy),
  .data_out_ready(data_out_ready)
);

`default_nettype wire

/* sim/burst_ram_model.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_ram_model
  import ramio_pkg::*;
#(
  parameter int ADDR_BITS = 12
) (
  input  wire           clk,
  input  wire           reset,
  input  wire           br_cmd,            // 0 read, 1 write
  input  wire           br_cmd_en,
  input  wire br_addr_t br_addr,
  input  wire beat_t    br_wr_data,
  input  wire [7:0]     br_data_mask,
  output beat_t         br_rd_data,
  output logic          br_rd_data_valid
);

  localparam int NUM_BEATS = (1 << ADDR_BITS) / 8;

  beat_t                mem [NUM_BEATS];
  logic [ADDR_BITS-4:0] wr_ix;
  int                   wr_left;
  logic [ADDR_BITS-4:0] rd_ix;
  int                   rd_wait;
  int                   rd_left;

  // a set mask bit keeps the stored byte
  function automatic beat_t apply_mask(input beat_t old_beat, input beat_t new_beat,
                                       input logic [7:0] mask);
    beat_t res;
    res = old_beat;
    for (int i = 0; i < 8; i++) begin
      if (!mask[i]) res[8*i +: 8] = new_beat[8*i +: 8];
    end
    return res;
  endfunction

  initial begin
    for (int i = 0; i < NUM_BEATS; i++) mem[i] = '0;
  end

  always @(posedge clk) begin
    if (reset) begin
      wr_left          <= 0;
      rd_wait          <= 0;
      rd_left          <= 0;
      br_rd_data_valid <= 1'b0;
    end else begin
      br_rd_data_valid <= 1'b0;
      // ----------------------------------------
      // write burst, first beat with the strobe
      // ----------------------------------------
      if (br_cmd_en && br_cmd) begin
        mem[br_addr[ADDR_BITS-1:3]] <= apply_mask(mem[br_addr[ADDR_BITS-1:3]], br_wr_data,
                                                  br_data_mask);
        wr_ix   <= br_addr[ADDR_BITS-1:3] + 1'b1;
        wr_left <= burst_beats - 1;
      end else if (wr_left > 0) begin
        mem[wr_ix] <= apply_mask(mem[wr_ix], br_wr_data, br_data_mask);
        wr_ix      <= wr_ix + 1'b1;
        wr_left    <= wr_left - 1;
      end
      // read burst after a random latency
      if (br_cmd_en && !br_cmd) begin
        rd_ix   <= br_addr[ADDR_BITS-1:3];
        rd_wait <= 3 + int'($urandom % 10);  // 3 to 12 cycles
        rd_left <= burst_beats;
      end else if (rd_wait > 1) begin
        rd_wait <= rd_wait - 1;
      end else if (rd_left > 0) begin
        br_rd_data_valid <= 1'b1;
        br_rd_data       <= mem[rd_ix];
        rd_ix            <= rd_ix + 1'b1;
        rd_left          <= rd_left - 1;
      end
    end
  end

endmodule

`default_nettype wire

/* source/ramio.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio
  import ramio_pkg::*;
#(
  parameter int RAM_DEPTH_BITWIDTH     = 21,
  parameter int CACHE_LINE_IX_BITWIDTH = 6,
  parameter int CLK_FREQ               = 30_000_000,
  parameter int BAUD_RATE              = 115_200
) (
  input  wire              clk,
  input  wire              reset,
  // core side
  input  wire              enable,
  input  wire write_type_t write_type,
  input  wire read_type_t  read_type,
  input  wire word_t       address,
  input  wire word_t       data_in,
  output word_t            data_out,
  output logic             data_out_ready,
  output logic             busy,
  output logic [3:0]       led,
  // uart
  output logic             uart_tx,
  input  wire              uart_rx,
  // burst ram
  output logic             br_cmd,
  output logic             br_cmd_en,
  output br_addr_t         br_addr,
  output beat_t            br_wr_data,
  output logic [7:0]       br_data_mask,
  input  wire beat_t       br_rd_data,
  input  wire              br_rd_data_valid
);

  typedef enum logic [2:0] {
    io_idle,
    io_led,
    io_tx,
    io_rx,
    io_respond
  } io_state_t;

  io_state_t  io_state;
  logic       addr_is_io;
  read_type_t req_rt;
  logic [1:0] req_lane;
  logic       req_to_io;
  byte_t      req_byte;
  word_t      io_word;
  word_t      cache_word;
  logic       cache_done;
  logic       access_done;
  logic       tx_start;
  logic       tx_busy;
  byte_t      rx_data;
  logic       rx_full;
  logic       rx_clear;
  byte_t      sel_byte;
  logic [15:0] sel_half;

  assign addr_is_io = (address == io_led_addr) || (address == io_uart_out_addr) ||
                      (address == io_uart_in_addr);

  assign tx_start       = (io_state == io_tx) && !tx_busy;  // waits while tx shifts
  assign rx_clear       = (io_state == io_rx);
  assign access_done    = cache_done || (io_state == io_respond);
  assign data_out_ready = access_done && (req_rt != rt_none);

  // ----------------------------------------
  // request tracking and i/o registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      busy     <= 1'b0;
      io_state <= io_idle;
      led      <= '0;
    end else begin
      if (enable) busy <= 1'b1;
      else if (access_done) busy <= 1'b0;
      case (io_state)
        io_idle: begin
          if (enable && address == io_led_addr) io_state <= io_led;
          else if (enable && address == io_uart_out_addr) io_state <= io_tx;
          else if (enable && address == io_uart_in_addr) io_state <= io_rx;
        end
        io_led: begin
          led      <= req_byte[3:0];
          io_state <= io_respond;
        end
        io_tx:      if (!tx_busy) io_state <= io_respond;
        io_rx:      io_state <= io_respond;
        io_respond: io_state <= io_idle;
        default:    io_state <= io_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (enable) begin
      req_rt    <= read_type;
      req_lane  <= address[1:0];
      req_to_io <= addr_is_io;
      req_byte  <= data_in[7:0];
    end
    if (io_state == io_rx) io_word <= rx_full ? word_t'(rx_data) : '1;  // all ones when empty
  end

  // ----------------------------------------
  // read data shaping
  // ----------------------------------------
  assign sel_byte = cache_word[req_lane*8 +: 8];
  assign sel_half = cache_word[req_lane[1]*16 +: 16];

  always_comb begin
    if (req_to_io) begin
      data_out = io_word;
    end else begin
      case (req_rt)
        rt_byte:   data_out = {{24{sel_byte[7]}}, sel_byte};
        rt_half:   data_out = {{16{sel_half[15]}}, sel_half};
        rt_byte_u: data_out = word_t'(sel_byte);
        rt_half_u: data_out = word_t'(sel_half);
        default:   data_out = cache_word;
      endcase
    end
  end

  // ----------------------------------------
  // submodules
  // ----------------------------------------
  ramio_cache #(
    .RAM_DEPTH_BITWIDTH    (RAM_DEPTH_BITWIDTH),
    .CACHE_LINE_IX_BITWIDTH(CACHE_LINE_IX_BITWIDTH)
  ) cache_i (
    .clk             (clk),
    .reset           (reset),
    .req             (enable && !addr_is_io),
    .write_type      (write_type),
    .address         (address),
    .data_in         (data_in),
    .read_word       (cache_word),
    .done            (cache_done),
    .br_cmd          (br_cmd),
    .br_cmd_en       (br_cmd_en),
    .br_addr         (br_addr),
    .br_wr_data      (br_wr_data),
    .br_data_mask    (br_data_mask),
    .br_rd_data      (br_rd_data),
    .br_rd_data_valid(br_rd_data_valid)
  );

  ramio_uart_tx #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD_RATE(BAUD_RATE)
  ) uart_tx_i (
    .clk  (clk),
    .reset(reset),
    .start(tx_start),
    .data (req_byte),
    .busy (tx_busy),
    .tx   (uart_tx)
  );

  ramio_uart_rx #(
    .CLK_FREQ (CLK_FREQ),
    .BAUD_RATE(BAUD_RATE)
  ) uart_rx_i (
    .clk  (clk),
    .reset(reset),
    .rx   (uart_rx),
    .clear(rx_clear),
    .data (rx_data),
    .full (rx_full)
  );

endmodule

`default_nettype wire

/* source/ramio_cache.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio_cache
  import ramio_pkg::*;
#(
  parameter int RAM_DEPTH_BITWIDTH     = 21,
  parameter int CACHE_LINE_IX_BITWIDTH = 6
) (
  input  wire              clk,
  input  wire              reset,
  input  wire              req,
  input  wire write_type_t write_type,
  input  wire word_t       address,
  input  wire word_t       data_in,
  output word_t            read_word,
  output logic             done,
  output logic             br_cmd,         // 0 read, 1 write
  output logic             br_cmd_en,
  output br_addr_t         br_addr,
  output beat_t            br_wr_data,
  output logic [7:0]       br_data_mask,
  input  wire beat_t       br_rd_data,
  input  wire              br_rd_data_valid
);

  localparam int NUM_LINES = 1 << CACHE_LINE_IX_BITWIDTH;
  localparam int OFFSET_W  = $clog2(line_bytes);
  localparam int BEAT_IX_W = $clog2(burst_beats);
  localparam int BEAT_LSB  = OFFSET_W - BEAT_IX_W;  // byte offset inside a beat
  localparam int TAG_W     = RAM_DEPTH_BITWIDTH - OFFSET_W - CACHE_LINE_IX_BITWIDTH;
  localparam logic [BEAT_IX_W-1:0] LAST_BEAT = BEAT_IX_W'(burst_beats - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_write_back,
    st_refill_wait,
    st_refill,
    st_respond
  } state_t;

  state_t state;

  word_t       req_addr;
  write_type_t req_wt;
  word_t       req_data;

  logic [BEAT_IX_W-1:0] beat_cnt;

  // line storage
  beat_t                data_mem [NUM_LINES*burst_beats];
  logic [TAG_W-1:0]     tag_mem  [NUM_LINES];
  logic [NUM_LINES-1:0] line_valid;
  logic [NUM_LINES-1:0] line_dirty;

  logic [CACHE_LINE_IX_BITWIDTH-1:0] ix;
  logic [TAG_W-1:0]                  tag;
  logic [BEAT_IX_W-1:0]              beat_ix;
  logic                              hit;
  beat_t                             cur_beat;
  beat_t                             merged_beat;
  br_addr_t                          fill_addr;
  br_addr_t                          evict_addr;

  // ----------------------------------------
  // address split and lookup
  // ----------------------------------------
  assign ix      = req_addr[OFFSET_W +: CACHE_LINE_IX_BITWIDTH];
  assign tag     = req_addr[OFFSET_W + CACHE_LINE_IX_BITWIDTH +: TAG_W];
  assign beat_ix = req_addr[BEAT_LSB +: BEAT_IX_W];

  assign cur_beat = data_mem[{ix, beat_ix}];
  assign hit      = line_valid[ix] && (tag_mem[ix] == tag);

  // upper bits beyond ram depth dropped, so addresses wrap
  assign fill_addr  = br_addr_t'({tag, ix, {OFFSET_W{1'b0}}});
  assign evict_addr = br_addr_t'({tag_mem[ix], ix, {OFFSET_W{1'b0}}});

  assign br_wr_data   = data_mem[{ix, beat_cnt}];  // beat follows the counter
  assign br_data_mask = '0;                        // full beats only
  assign done         = (state == st_respond);

  // byte lane merge for store hits
  always_comb begin
    merged_beat = cur_beat;
    case (req_wt)
      wt_byte: merged_beat[req_addr[2:0]*8 +: 8]   = req_data[7:0];
      wt_half: merged_beat[req_addr[2:1]*16 +: 16] = req_data[15:0];
      wt_word: merged_beat[req_addr[2]*32 +: 32]   = req_data;
      default: ;
    endcase
  end

  // ----------------------------------------
  // control fsm
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      br_cmd_en  <= 1'b0;
      br_cmd     <= 1'b0;
      beat_cnt   <= '0;
      line_valid <= '0;
      line_dirty <= '0;
    end else begin
      br_cmd_en <= 1'b0;  // strobe
      case (state)
        st_idle: begin
          if (req) state <= st_lookup;
        end
        st_lookup: begin
          if (hit) begin
            if (req_wt != wt_none) line_dirty[ix] <= 1'b1;
            state <= st_respond;
          end else if (line_valid[ix] && line_dirty[ix]) begin
            br_cmd_en <= 1'b1;
            br_cmd    <= 1'b1;
            br_addr   <= evict_addr;
            beat_cnt  <= '0;
            state     <= st_write_back;
          end else begin
            br_cmd_en <= 1'b1;
            br_cmd    <= 1'b0;
            br_addr   <= fill_addr;
            beat_cnt  <= '0;
            state     <= st_refill_wait;
          end
        end
        st_write_back: begin
          beat_cnt <= beat_cnt + 1'b1;  // wraps to 0 for the refill
          if (beat_cnt == LAST_BEAT) begin
            br_cmd_en <= 1'b1;  // write burst done, fetch the new line
            br_cmd    <= 1'b0;
            br_addr   <= fill_addr;
            state     <= st_refill_wait;
          end
        end
        st_refill_wait: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            state    <= st_refill;
          end
        end
        st_refill: begin
          if (br_rd_data_valid) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (beat_cnt == LAST_BEAT) begin
              line_valid[ix] <= 1'b1;
              line_dirty[ix] <= 1'b0;
              state          <= st_lookup;  // retry as a hit
            end
          end
        end
        st_respond: state <= st_idle;
        default:    state <= st_idle;
      endcase
    end
  end

  // ----------------------------------------
  // request capture and line storage
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (state == st_idle && req) begin
      req_addr <= address;
      req_wt   <= write_type;
      req_data <= data_in;
    end
    if (state == st_lookup && hit) read_word <= cur_beat[req_addr[2]*32 +: 32];
    if (state == st_lookup && hit && req_wt != wt_none) begin
      data_mem[{ix, beat_ix}] <= merged_beat;
    end else if ((state == st_refill_wait || state == st_refill) && br_rd_data_valid) begin
      data_mem[{ix, beat_cnt}] <= br_rd_data;
    end
    if (state == st_refill && br_rd_data_valid && beat_cnt == LAST_BEAT) tag_mem[ix] <= tag;
  end

endmodule

`default_nettype wire

/* source/ramio_uart_rx.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio_uart_rx
  import ramio_pkg::*;
#(
  parameter int CLK_FREQ  = 30_000_000,
  parameter int BAUD_RATE = 115_200
) (
  input  wire  clk,
  input  wire  reset,
  input  wire  rx,
  input  wire  clear,
  output byte_t data,
  output logic full
);

  localparam int CYCLES_PER_BIT = CLK_FREQ / BAUD_RATE;
  localparam int TIMER_W        = $clog2(CYCLES_PER_BIT + 1);
  localparam logic [TIMER_W-1:0] BIT_END  = TIMER_W'(CYCLES_PER_BIT - 1);
  localparam logic [TIMER_W-1:0] HALF_END = TIMER_W'(CYCLES_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start_bit,
    rx_data_bits,
    rx_stop_bit
  } rx_state_t;

  rx_state_t          state;
  logic [TIMER_W-1:0] timer;
  logic [2:0]         bit_ix;
  byte_t              shift;
  logic               rx_meta;
  logic               rx_sync;
  logic               bit_end;
  logic               stop_ok;

  assign bit_end = (timer == BIT_END);
  assign stop_ok = (state == rx_stop_bit) && bit_end && rx_sync;

  always_ff @(posedge clk) begin
    if (reset) begin
      rx_meta <= 1'b1;  // line idles high
      rx_sync <= 1'b1;
      state   <= rx_idle;
      timer   <= '0;
      bit_ix  <= '0;
      full    <= 1'b0;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      case (state)
        rx_idle: begin
          timer <= '0;
          if (!rx_sync) state <= rx_start_bit;
        end
        rx_start_bit: begin
          // check start bit at its middle
          if (timer == HALF_END) begin
            timer  <= '0;
            bit_ix <= '0;
            state  <= rx_sync ? rx_idle : rx_data_bits;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        rx_data_bits: begin
          if (bit_end) begin
            timer  <= '0;
            bit_ix <= bit_ix + 1'b1;
            if (bit_ix == 3'd7) state <= rx_stop_bit;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        rx_stop_bit: begin
          if (bit_end) begin
            timer <= '0;
            state <= rx_idle;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        default: state <= rx_idle;
      endcase
      if (stop_ok) full <= 1'b1;  // new byte wins over clear
      else if (clear) full <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == rx_data_bits && bit_end) shift <= {rx_sync, shift[7:1]};
    if (stop_ok) data <= shift;
  end

endmodule

`default_nettype wire

/* source/ramio_uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module ramio_uart_tx
  import ramio_pkg::*;
#(
  parameter int CLK_FREQ  = 30_000_000,
  parameter int BAUD_RATE = 115_200
) (
  input  wire        clk,
  input  wire        reset,
  input  wire        start,
  input  wire byte_t data,
  output logic       busy,
  output logic       tx
);

  localparam int CYCLES_PER_BIT = CLK_FREQ / BAUD_RATE;
  localparam int TIMER_W        = $clog2(CYCLES_PER_BIT + 1);
  localparam logic [TIMER_W-1:0] BIT_END = TIMER_W'(CYCLES_PER_BIT - 1);

  typedef enum logic [1:0] {
    tx_idle,
    tx_start_bit,
    tx_data_bits,
    tx_stop_bit
  } tx_state_t;

  tx_state_t          state;
  logic [TIMER_W-1:0] timer;
  logic [2:0]         bit_ix;
  byte_t              shift;
  logic               bit_end;

  assign bit_end = (timer == BIT_END);
  assign busy    = (state != tx_idle);

  always_ff @(posedge clk) begin
    if (reset) begin
      state  <= tx_idle;
      timer  <= '0;
      bit_ix <= '0;
    end else begin
      if (state == tx_idle || bit_end) timer <= '0;
      else timer <= timer + 1'b1;
      case (state)
        tx_idle:      if (start) state <= tx_start_bit;
        tx_start_bit: begin
          if (bit_end) begin
            bit_ix <= '0;
            state  <= tx_data_bits;
          end
        end
        tx_data_bits: begin
          if (bit_end) begin
            bit_ix <= bit_ix + 1'b1;
            if (bit_ix == 3'd7) state <= tx_stop_bit;
          end
        end
        tx_stop_bit:  if (bit_end) state <= tx_idle;
        default:      state <= tx_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == tx_idle && start) shift <= data;
    else if (state == tx_data_bits && bit_end) shift <= shift >> 1;  // lsb first
  end

  always_comb begin
    case (state)
      tx_start_bit: tx = 1'b0;
      tx_data_bits: tx = shift[0];
      default:      tx = 1'b1;  // idle and stop are mark
    endcase
  end

endmodule

`default_nettype wire

/* source/ramio_pkg.sv */
`default_nettype none

package ramio_pkg;

  // ----------------------------------------
  // widths with a meaning
  // ----------------------------------------
  typedef logic [31:0] word_t;     // core address or data word
  typedef logic [7:0]  byte_t;     // uart and led byte
  typedef logic [63:0] beat_t;     // one burst beat
  typedef logic [20:0] br_addr_t;  // burst ram byte address

  // ----------------------------------------
  // access types from the core
  // ----------------------------------------
  typedef enum logic [1:0] {
    wt_none,
    wt_byte,
    wt_half,
    wt_word
  } write_type_t;

  // plain byte/half sign-extend, _u variants zero-extend
  typedef enum logic [2:0] {
    rt_none,
    rt_byte,
    rt_half,
    rt_word,
    rt_byte_u,
    rt_half_u
  } read_type_t;

  // ----------------------------------------
  // memory-mapped i/o, top of address space
  // ----------------------------------------
  localparam word_t io_led_addr      = 32'hFFFF_FFFF;
  localparam word_t io_uart_out_addr = 32'hFFFF_FFFE;
  localparam word_t io_uart_in_addr  = 32'hFFFF_FFFD;

  // cache line geometry
  localparam int burst_beats = 4;   // beats per line
  localparam int line_bytes  = 32;  // bytes per line

endpackage

`default_nettype wire
